/* source/collision_pkg.sv */
/*
 * Shared widths, body numbering and contact types for the collision force
 * pipeline. Imported by the RTL stages and by the testbench.
 */
`default_nettype none

package collision_pkg;

    localparam int VEL_W     = 17;
    localparam int NUM_BIRDS = 3;

    // Signed velocity or force, two's complement
    typedef logic signed [VEL_W-1:0] velocity_t;

    // Birds 0 to 2, pig always last
    typedef logic [1:0] body_idx_t;

    localparam body_idx_t PIG_IDX = 2'd3;

    // Raw code from the game logic
    typedef logic [3:0] dir_code_t;

    // Compass heading, 0 is up and the rest go clockwise
    typedef logic [2:0] heading_t;

    typedef enum logic [1:0] {
        CONTACT_NONE = 2'd0,
        CONTACT_PAIR = 2'd1,
        CONTACT_PILE = 2'd2
    } contact_kind_t;

endpackage

`default_nettype wire

/* source/contact_select.sv */
/*
 * Classifies the contact mask as none, pair or pile and steers the two
 * bodies of a pair, their velocities and the striker's code to the pair stage.
 */
`timescale 1ns/100ps
`default_nettype none

module contact_select (
    input  logic [3:0]                                             collide,
    input  collision_pkg::velocity_t [collision_pkg::NUM_BIRDS-1:0] bird_vx,
    input  collision_pkg::velocity_t [collision_pkg::NUM_BIRDS-1:0] bird_vy,
    input  collision_pkg::velocity_t                                pig_vx,
    input  collision_pkg::velocity_t                                pig_vy,
    input  collision_pkg::dir_code_t [collision_pkg::NUM_BIRDS-1:0] bird_dir,
    output collision_pkg::contact_kind_t                            kind,
    output collision_pkg::body_idx_t                                striker,
    output collision_pkg::body_idx_t                                struck,
    output collision_pkg::velocity_t                                striker_vx,
    output collision_pkg::velocity_t                                striker_vy,
    output collision_pkg::velocity_t                                struck_vx,
    output collision_pkg::velocity_t                                struck_vy,
    output collision_pkg::dir_code_t                                striker_dir
);

    import collision_pkg::*;

    logic [2:0] bits_set;

    function automatic velocity_t body_vel(
        input body_idx_t                   idx,
        input velocity_t [NUM_BIRDS-1:0]   birds,
        input velocity_t                   pig
    );
        if (idx == PIG_IDX) begin
            return pig;
        end
        return birds[idx];
    endfunction

    assign bits_set = 3'($countones(collide));

    always_comb begin
        kind    = CONTACT_NONE;
        striker = 2'd0;
        struck  = 2'd0;
        if (bits_set >= 3'd3) begin
            kind = CONTACT_PILE;
        end else if (bits_set == 3'd2) begin
            kind = CONTACT_PAIR;
            // Highest bird in the pair strikes
            if (collide[3]) begin
                striker = 2'd2;
            end else if (collide[2]) begin
                striker = 2'd1;
            end else begin
                striker = 2'd0;
            end
            // Pig is hit whenever present, else the lower bird
            if (collide[0]) begin
                struck = PIG_IDX;
            end else if (collide[1]) begin
                struck = 2'd0;
            end else begin
                struck = 2'd1;
            end
        end
    end

    assign striker_vx = body_vel(striker, bird_vx, pig_vx);
    assign striker_vy = body_vel(striker, bird_vy, pig_vy);
    assign struck_vx  = body_vel(struck, bird_vx, pig_vx);
    assign struck_vy  = body_vel(struck, bird_vy, pig_vy);

    // Striker is always a bird
    assign striker_dir = bird_dir[striker];

endmodule

`default_nettype wire

/* source/pair_response.sv */
/*
 * Pair stage. Decodes the striker's heading, looks up the impulse response
 * for both bodies and flags a slow contact. Purely combinational.
 */
`timescale 1ns/100ps
`default_nettype none

module pair_response #(
    parameter int SLOW_LIMIT = 64
) (
    input  collision_pkg::velocity_t striker_vx,
    input  collision_pkg::velocity_t striker_vy,
    input  collision_pkg::velocity_t struck_vx,
    input  collision_pkg::velocity_t struck_vy,
    input  collision_pkg::dir_code_t striker_dir,
    output collision_pkg::velocity_t striker_fx,
    output collision_pkg::velocity_t striker_fy,
    output collision_pkg::velocity_t struck_fx,
    output collision_pkg::velocity_t struck_fy,
    output logic                     slow
);

    import collision_pkg::*;

    heading_t  heading;
    velocity_t s_half_x;
    velocity_t s_half_y;
    velocity_t s_quarter_x;
    velocity_t mag_s_x;
    velocity_t mag_s_y;
    velocity_t mag_t_x;
    velocity_t mag_t_y;

    function automatic velocity_t magnitude(input velocity_t v);
        return (v < 0) ? -v : v;
    endfunction

    always_comb begin
        case (striker_dir)
            4'b1000, 4'b1010: heading = 3'd0;
            4'b1001, 4'b1011: heading = 3'd4;
            4'b0110, 4'b0111: heading = 3'd2;
            4'b0100, 4'b0101: heading = 3'd6;
            4'b0010:          heading = 3'd1;
            4'b0011:          heading = 3'd3;
            4'b0001:          heading = 3'd5;
            4'b0000:          heading = 3'd7;
            default:          heading = 3'd0;  // 11xx counts as up
        endcase
    end

    assign s_half_x    = striker_vx >>> 1;
    assign s_half_y    = striker_vy >>> 1;
    assign s_quarter_x = striker_vx >>> 2;

    // Impulse table, one row per heading
    always_comb begin
        case (heading)
            3'd0: begin
                striker_fx = struck_vx - s_quarter_x;
                striker_fy = struck_vy - s_half_y;
                struck_fx  = s_half_x;
                struck_fy  = striker_vy;
            end
            3'd1: begin
                striker_fx = struck_vx - s_half_x;
                striker_fy = struck_vy - s_half_y;
                struck_fx  = striker_vx;
                struck_fy  = striker_vy;
            end
            3'd2: begin
                striker_fx = struck_vx - s_half_x;
                striker_fy = struck_vy;
                struck_fx  = striker_vx;
                struck_fy  = s_half_y;
            end
            3'd3, 3'd4: begin
                striker_fx = struck_vx - s_half_x;
                striker_fy = struck_vy - s_half_y;
                struck_fx  = s_half_x;
                struck_fy  = s_half_y;
            end
            3'd5: begin
                striker_fx = struck_vx - s_half_x;
                striker_fy = struck_vy - s_half_y;
                struck_fx  = -s_half_x;
                struck_fy  = s_half_y;
            end
            3'd6: begin
                striker_fx = struck_vx - s_half_x;
                striker_fy = struck_vy - s_half_y;
                struck_fx  = s_half_x;
                struck_fy  = striker_vy;
            end
            default: begin
                // Heading 7
                striker_fx = struck_vx - s_half_x;
                striker_fy = struck_vy - s_half_y;
                struck_fx  = striker_vx;
                struck_fy  = striker_vy;
            end
        endcase
    end

    assign mag_s_x = magnitude(striker_vx);
    assign mag_s_y = magnitude(striker_vy);
    assign mag_t_x = magnitude(struck_vx);
    assign mag_t_y = magnitude(struck_vy);

    // Both bodies nearly at rest
    assign slow = (mag_s_x < SLOW_LIMIT) && (mag_s_y < SLOW_LIMIT) &&
                  (mag_t_x < SLOW_LIMIT) && (mag_t_y < SLOW_LIMIT);

endmodule

`default_nettype wire

/* source/force_latch.sv */
/*
 * Places pair, slow repel or pile forces into the per-body slots and
 * registers them on the frame strobe. Outputs hold between strobes.
 */
`timescale 1ns/100ps
`default_nettype none

module force_latch #(
    parameter int STICK_REPEL = 40
) (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    vsync,
    input  logic [3:0]                                              collide,
    input  collision_pkg::contact_kind_t                            kind,
    input  collision_pkg::body_idx_t                                striker,
    input  collision_pkg::body_idx_t                                struck,
    input  collision_pkg::velocity_t                                striker_fx,
    input  collision_pkg::velocity_t                                striker_fy,
    input  collision_pkg::velocity_t                                struck_fx,
    input  collision_pkg::velocity_t                                struck_fy,
    input  logic                                                    slow,
    output collision_pkg::velocity_t [collision_pkg::NUM_BIRDS-1:0] bird_force_x,
    output collision_pkg::velocity_t [collision_pkg::NUM_BIRDS-1:0] bird_force_y,
    output collision_pkg::velocity_t                                pig_force_x,
    output collision_pkg::velocity_t                                pig_force_y
);

    import collision_pkg::*;

    localparam velocity_t REPEL = velocity_t'(STICK_REPEL);

    // One slot per body, pig in the last slot
    velocity_t next_fx [NUM_BIRDS+1];
    velocity_t next_fy [NUM_BIRDS+1];
    body_idx_t lower;
    body_idx_t top_bird;

    // Pig numbers highest, so it is never the lower body
    assign lower = (striker < struck) ? striker : struck;

    always_comb begin
        top_bird = 2'd0;
        for (int i = 0; i < NUM_BIRDS; i++) begin
            if (collide[i+1]) begin
                top_bird = body_idx_t'(i);
            end
        end
    end

    always_comb begin
        for (int b = 0; b <= NUM_BIRDS; b++) begin
            next_fx[b] = '0;
            next_fy[b] = '0;
        end
        if (kind == CONTACT_PAIR) begin
            if (slow) begin
                next_fx[striker] = -REPEL;
                next_fy[striker] = -REPEL;
                next_fx[struck]  = -REPEL;
                next_fy[struck]  = -REPEL;
                next_fx[lower]   = REPEL;
            end else begin
                next_fx[striker] = striker_fx;
                next_fy[striker] = striker_fy;
                next_fx[struck]  = struck_fx;
                next_fy[struck]  = struck_fy;
            end
        end else if (kind == CONTACT_PILE) begin
            for (int i = 0; i < NUM_BIRDS; i++) begin
                if (collide[i+1]) begin
                    next_fx[i] = (body_idx_t'(i) == top_bird) ? -REPEL : REPEL;
                    next_fy[i] = -REPEL;
                end
            end
            // Pig at the bottom only gets pushed up
            if (collide[0]) begin
                next_fy[PIG_IDX] = -REPEL;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bird_force_x <= '0;
            bird_force_y <= '0;
            pig_force_x  <= '0;
            pig_force_y  <= '0;
        end else if (vsync) begin
            for (int i = 0; i < NUM_BIRDS; i++) begin
                bird_force_x[i] <= next_fx[i];
                bird_force_y[i] <= next_fy[i];
            end
            pig_force_x <= next_fx[PIG_IDX];
            pig_force_y <= next_fy[PIG_IDX];
        end
    end

endmodule

`default_nettype wire

/* source/collision_top.sv */
/*
 * Top level of the contact force pipeline. Chains mask selection, the
 * shared pair stage and the frame latch, and passes the parameters down.
 */
`timescale 1ns/100ps
`default_nettype none

module collision_top #(
    parameter int STICK_REPEL = 40,
    parameter int SLOW_LIMIT  = 64
) (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    vsync,
    input  logic [3:0]                                              collide,
    input  collision_pkg::dir_code_t [collision_pkg::NUM_BIRDS-1:0] bird_dir,
    input  collision_pkg::dir_code_t                                pig_dir,
    input  collision_pkg::velocity_t [collision_pkg::NUM_BIRDS-1:0] bird_vx,
    input  collision_pkg::velocity_t [collision_pkg::NUM_BIRDS-1:0] bird_vy,
    input  collision_pkg::velocity_t                                pig_vx,
    input  collision_pkg::velocity_t                                pig_vy,
    output collision_pkg::velocity_t [collision_pkg::NUM_BIRDS-1:0] bird_force_x,
    output collision_pkg::velocity_t [collision_pkg::NUM_BIRDS-1:0] bird_force_y,
    output collision_pkg::velocity_t                                pig_force_x,
    output collision_pkg::velocity_t                                pig_force_y
);

    import collision_pkg::*;

    contact_kind_t kind;
    body_idx_t     striker;
    body_idx_t     struck;
    velocity_t     striker_vx;
    velocity_t     striker_vy;
    velocity_t     struck_vx;
    velocity_t     struck_vy;
    dir_code_t     striker_dir;
    velocity_t     striker_fx;
    velocity_t     striker_fy;
    velocity_t     struck_fx;
    velocity_t     struck_fy;
    logic          slow;

    // The pig never strikes, so pig_dir stops here
    contact_select contact_select_inst (
        .collide     (collide),
        .bird_vx     (bird_vx),
        .bird_vy     (bird_vy),
        .pig_vx      (pig_vx),
        .pig_vy      (pig_vy),
        .bird_dir    (bird_dir),
        .kind        (kind),
        .striker     (striker),
        .struck      (struck),
        .striker_vx  (striker_vx),
        .striker_vy  (striker_vy),
        .struck_vx   (struck_vx),
        .struck_vy   (struck_vy),
        .striker_dir (striker_dir)
    );

    pair_response #(
        .SLOW_LIMIT (SLOW_LIMIT)
    ) pair_response_inst (
        .striker_vx  (striker_vx),
        .striker_vy  (striker_vy),
        .struck_vx   (struck_vx),
        .struck_vy   (struck_vy),
        .striker_dir (striker_dir),
        .striker_fx  (striker_fx),
        .striker_fy  (striker_fy),
        .struck_fx   (struck_fx),
        .struck_fy   (struck_fy),
        .slow        (slow)
    );

    force_latch #(
        .STICK_REPEL (STICK_REPEL)
    ) force_latch_inst (
        .clk          (clk),
        .rst          (rst),
        .vsync        (vsync),
        .collide      (collide),
        .kind         (kind),
        .striker      (striker),
        .struck       (struck),
        .striker_fx   (striker_fx),
        .striker_fy   (striker_fy),
        .struck_fx    (struck_fx),
        .struck_fy    (struck_fy),
        .slow         (slow),
        .bird_force_x (bird_force_x),
        .bird_force_y (bird_force_y),
        .pig_force_x  (pig_force_x),
        .pig_force_y  (pig_force_y)
    );

endmodule

`default_nettype wire

/* tb/collision_chk.sv */
/*
 * Assertions on the frame latch, bound to force_latch. Checks reset
 * clearing and that the force outputs hold on edges without vsync.
 */
`timescale 1ns/100ps
`default_nettype none

module collision_chk (
    input logic                                                    clk,
    input logic                                                    rst,
    input logic                                                    vsync,
    input collision_pkg::velocity_t [collision_pkg::NUM_BIRDS-1:0] bird_force_x,
    input collision_pkg::velocity_t [collision_pkg::NUM_BIRDS-1:0] bird_force_y,
    input collision_pkg::velocity_t                                pig_force_x,
    input collision_pkg::velocity_t                                pig_force_y
);

    logic [8*collision_pkg::VEL_W-1:0] all_forces;
    int                                assert_errors = 0;

    assign all_forces = {bird_force_x, bird_force_y, pig_force_x, pig_force_y};

    reset_clears: assert property (@(posedge clk) rst |=> all_forces == '0)
        else begin
            $error("force outputs not cleared after reset");
            assert_errors++;
        end

    // No strobe, no change
    hold_without_vsync: assert property (
        @(posedge clk) (!rst && !vsync) |=> $stable(all_forces))
        else begin
            $error("force outputs changed on an edge without vsync");
            assert_errors++;
        end

endmodule

bind force_latch collision_chk collision_chk_inst (
    .clk          (clk),
    .rst          (rst),
    .vsync        (vsync),
    .bird_force_x (bird_force_x),
    .bird_force_y (bird_force_y),
    .pig_force_x  (pig_force_x),
    .pig_force_y  (pig_force_y)
);

`default_nettype wire

/* include/collision_model.svh */
/*
 * Reference model of the contact force rules, included inside the
 * testbench module to compute expected forces.
 */
`ifndef COLLISION_MODEL_SVH
`define COLLISION_MODEL_SVH

function automatic collision_pkg::heading_t model_heading(
    input collision_pkg::dir_code_t code
);
    casez (code)
        4'b11??, 4'b1000, 4'b1010: return 3'd0;
        4'b1001, 4'b1011:          return 3'd4;
        4'b011?:                   return 3'd2;
        4'b010?:                   return 3'd6;
        4'b0010:                   return 3'd1;
        4'b0011:                   return 3'd3;
        4'b0001:                   return 3'd5;
        default:                   return 3'd7;
    endcase
endfunction

// Forces on striker (s) and struck body (t) for a fast pair
function automatic void model_pair(
    input  collision_pkg::heading_t  hd,
    input  collision_pkg::velocity_t s_vx,
    input  collision_pkg::velocity_t s_vy,
    input  collision_pkg::velocity_t t_vx,
    input  collision_pkg::velocity_t t_vy,
    output collision_pkg::velocity_t s_fx,
    output collision_pkg::velocity_t s_fy,
    output collision_pkg::velocity_t t_fx,
    output collision_pkg::velocity_t t_fy
);
    s_fx = (hd == 3'd0) ? t_vx - (s_vx >>> 2) : t_vx - (s_vx >>> 1);
    s_fy = (hd == 3'd2) ? t_vy : t_vy - (s_vy >>> 1);
    if (hd inside {3'd1, 3'd2, 3'd7}) begin
        t_fx = s_vx;
    end else if (hd == 3'd5) begin
        t_fx = -(s_vx >>> 1);
    end else begin
        t_fx = s_vx >>> 1;
    end
    t_fy = (hd inside {3'd0, 3'd1, 3'd6, 3'd7}) ? s_vy : s_vy >>> 1;
endfunction

// Pile force on one body, birds 0 to 2 and pig 3
function automatic collision_pkg::velocity_t model_pile(
    input logic [3:0] collide,
    input int         body,
    input bit         y_axis,
    input int         repel
);
    int   top;
    logic present;
    top = 0;
    for (int i = 0; i < collision_pkg::NUM_BIRDS; i++) begin
        if (collide[i+1]) begin
            top = i;
        end
    end
    present = (body == 3) ? collide[0] : collide[body+1];
    if (!present) begin
        return '0;
    end
    if (y_axis) begin
        return collision_pkg::velocity_t'(-repel);
    end
    if (body == 3) begin
        return '0;
    end
    return collision_pkg::velocity_t'((body == top) ? -repel : repel);
endfunction

`endif

/* tb/collision_tb.sv */
/*
 * Directed testbench for collision_top. Drives contact frames, computes
 * expected forces with the reference model and compares every output.
 */
`timescale 1ns/100ps
`default_nettype none

module collision_tb;

    import collision_pkg::*;

    `include "collision_model.svh"

    localparam int PERIOD      = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int STICK_REPEL = 40;
    localparam int SLOW_LIMIT  = 64;
    // reset/hold 5, bird-pig 48, bird-bird 24, slow 96, pile/idle 15
    localparam int NUM_FRAMES  = 188;
    localparam velocity_t REPEL = velocity_t'(STICK_REPEL);

    logic                            clk;
    logic                            rst;
    logic                            vsync;
    logic [3:0]                      collide;
    dir_code_t [NUM_BIRDS-1:0]       bird_dir;
    dir_code_t                       pig_dir;
    velocity_t [NUM_BIRDS-1:0]       bird_vx;
    velocity_t [NUM_BIRDS-1:0]       bird_vy;
    velocity_t                       pig_vx;
    velocity_t                       pig_vy;
    velocity_t [NUM_BIRDS-1:0]       bird_force_x;
    velocity_t [NUM_BIRDS-1:0]       bird_force_y;
    velocity_t                       pig_force_x;
    velocity_t                       pig_force_y;

    logic [31:0] lfsr_state = 32'h1d3b_4072;
    int          checks = 0;
    int          errors = 0;
    velocity_t   exp_fx [NUM_BIRDS+1];
    velocity_t   exp_fy [NUM_BIRDS+1];

    collision_top #(
        .STICK_REPEL (STICK_REPEL),
        .SLOW_LIMIT  (SLOW_LIMIT)
    ) collision_top_inst (
        .clk          (clk),
        .rst          (rst),
        .vsync        (vsync),
        .collide      (collide),
        .bird_dir     (bird_dir),
        .pig_dir      (pig_dir),
        .bird_vx      (bird_vx),
        .bird_vy      (bird_vy),
        .pig_vx       (pig_vx),
        .pig_vy       (pig_vy),
        .bird_force_x (bird_force_x),
        .bird_force_y (bird_force_y),
        .pig_force_x  (pig_force_x),
        .pig_force_y  (pig_force_y)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_FRAMES * 3 + 20) * PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    function automatic velocity_t rand_vel(input bit slow_range);
        logic [31:0] r;
        if (slow_range) begin
            r = take_bits(7);
            return velocity_t'(int'(r % 127) - 63);
        end
        r = take_bits(17);
        return velocity_t'(int'(r % 120001) - 60000);
    endfunction

    function automatic velocity_t body_vel(input int b, input bit y);
        if (b == 3) begin
            return y ? pig_vy : pig_vx;
        end
        return y ? bird_vy[b] : bird_vx[b];
    endfunction

    function automatic bit is_slow_vel(input velocity_t v);
        return (v > -SLOW_LIMIT) && (v < SLOW_LIMIT);
    endfunction

    function automatic void compute_expected();
        int        lo;
        int        hi;
        int        t;
        velocity_t sfx;
        velocity_t sfy;
        velocity_t tfx;
        velocity_t tfy;
        lo = -1;
        hi = -1;
        for (int b = 0; b <= NUM_BIRDS; b++) begin
            exp_fx[b] = '0;
            exp_fy[b] = '0;
        end
        for (int i = 0; i < NUM_BIRDS; i++) begin
            if (collide[i+1]) begin
                if (lo < 0) lo = i;
                hi = i;
            end
        end
        if ($countones(collide) >= 3) begin
            for (int b = 0; b <= NUM_BIRDS; b++) begin
                exp_fx[b] = model_pile(collide, b, 1'b0, STICK_REPEL);
                exp_fy[b] = model_pile(collide, b, 1'b1, STICK_REPEL);
            end
        end else if ($countones(collide) == 2) begin
            // Highest bird strikes; pig is struck when present
            t = collide[0] ? 3 : lo;
            if (is_slow_vel(body_vel(hi, 0)) && is_slow_vel(body_vel(hi, 1)) &&
                is_slow_vel(body_vel(t, 0)) && is_slow_vel(body_vel(t, 1))) begin
                exp_fx[hi] = -REPEL;
                exp_fy[hi] = -REPEL;
                exp_fx[t]  = -REPEL;
                exp_fy[t]  = -REPEL;
                exp_fx[(hi < t) ? hi : t] = REPEL;
            end else begin
                model_pair(model_heading(bird_dir[hi]), body_vel(hi, 0), body_vel(hi, 1),
                           body_vel(t, 0), body_vel(t, 1), sfx, sfy, tfx, tfy);
                exp_fx[hi] = sfx;
                exp_fy[hi] = sfy;
                exp_fx[t]  = tfx;
                exp_fy[t]  = tfy;
            end
        end
    endfunction

    task automatic randomize_inputs(input bit slow_range);
        for (int i = 0; i < NUM_BIRDS; i++) begin
            bird_vx[i]  = rand_vel(slow_range);
            bird_vy[i]  = rand_vel(slow_range);
            bird_dir[i] = dir_code_t'(take_bits(4));
        end
        pig_vx  = rand_vel(slow_range);
        pig_vy  = rand_vel(slow_range);
        pig_dir = dir_code_t'(take_bits(4));
    endtask

    task automatic check_force(input string name, input velocity_t expected,
                               input velocity_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_outputs(input string test);
        for (int b = 0; b < NUM_BIRDS; b++) begin
            check_force($sformatf("%s bird%0d_fx", test, b), exp_fx[b], bird_force_x[b]);
            check_force($sformatf("%s bird%0d_fy", test, b), exp_fy[b], bird_force_y[b]);
        end
        check_force({test, " pig_fx"}, exp_fx[3], pig_force_x);
        check_force({test, " pig_fy"}, exp_fy[3], pig_force_y);
    endtask

    // Inputs are already driven; strobe one frame and check after the edge
    task automatic latch_and_check(input string test);
        vsync = 1'b1;
        compute_expected();
        @(posedge clk);
        #DRIVE_DLY;
        vsync = 1'b0;
        check_outputs(test);
    endtask

    task automatic report_test(input string test, input int frames, input int start_errors);
        $display("%-10s %0d frames, %0d errors", test, frames, errors - start_errors);
    endtask

    task automatic test_reset_hold();
        int e0;
        e0 = errors;
        for (int b = 0; b <= NUM_BIRDS; b++) begin
            exp_fx[b] = '0;
            exp_fy[b] = '0;
        end
        check_outputs("reset");
        collide = 4'b0011;
        randomize_inputs(1'b0);
        latch_and_check("hold");
        // New inputs without a strobe must not reach the outputs
        collide = 4'b1111;
        randomize_inputs(1'b0);
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        check_outputs("hold");
        report_test("reset_hold", 1, e0);
    endtask

    task automatic test_bird_pig();
        int e0;
        e0 = errors;
        for (int b = 0; b < NUM_BIRDS; b++) begin
            for (int code = 0; code < 16; code++) begin
                collide = 4'b0001 | (4'b0010 << b);
                randomize_inputs(1'b0);
                bird_dir[b] = dir_code_t'(code);
                latch_and_check("bird_pig");
            end
        end
        report_test("bird_pig", 48, e0);
    endtask

    task automatic test_bird_bird();
        logic [3:0] masks [3] = '{4'b0110, 4'b1010, 4'b1100};
        int         e0;
        e0 = errors;
        foreach (masks[m]) begin
            repeat (8) begin
                collide = masks[m];
                randomize_inputs(1'b0);
                latch_and_check("bird_bird");
            end
        end
        report_test("bird_bird", 24, e0);
    endtask

    task automatic test_slow();
        logic [3:0] masks [6] = '{4'b0011, 4'b0101, 4'b1001, 4'b0110, 4'b1010, 4'b1100};
        int         e0;
        e0 = errors;
        foreach (masks[m]) begin
            for (int code = 0; code < 16; code++) begin
                collide = masks[m];
                randomize_inputs(1'b1);
                bird_dir = {3{dir_code_t'(code)}};
                latch_and_check("slow");
            end
        end
        report_test("slow", 96, e0);
    endtask

    task automatic test_pile_idle();
        logic [3:0] piles [5] = '{4'b0111, 4'b1011, 4'b1101, 4'b1110, 4'b1111};
        logic [3:0] idle [5]  = '{4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000};
        int         e0;
        e0 = errors;
        foreach (piles[m]) begin
            for (int s = 0; s < 2; s++) begin
                collide = piles[m];
                randomize_inputs(s[0]);
                latch_and_check("pile");
            end
        end
        foreach (idle[m]) begin
            collide = idle[m];
            randomize_inputs(1'b0);
            latch_and_check("idle");
        end
        report_test("pile_idle", 15, e0);
    endtask

    initial begin
        int assert_fails;
        rst      = 1'b1;
        vsync    = 1'b0;
        collide  = '0;
        bird_dir = '0;
        pig_dir  = '0;
        bird_vx  = '0;
        bird_vy  = '0;
        pig_vx   = '0;
        pig_vy   = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        test_reset_hold();
        test_bird_pig();
        test_bird_bird();
        test_slow();
        test_pile_idle();
        @(posedge clk);
        #DRIVE_DLY;
        assert_fails = collision_top_inst.force_latch_inst.collision_chk_inst.assert_errors;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* collision.f */
+incdir+include
source/collision_pkg.sv
source/contact_select.sv
source/pair_response.sv
source/force_latch.sv
source/collision_top.sv
tb/collision_chk.sv
tb/collision_tb.sv
